/* include/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Buffer geometry
// Number of in-flight slots, kept a power of two so the index wraps cleanly
`define ROB_DEPTH 16

// Bits needed to address one slot
`define ROB_IDX_W 4

// Register and datapath widths
// Physical register file holds 64 entries
`define PREG_W 6

// Data and PC width of the core
`define XLEN 32

// Architectural register number width
`define AREG_W 5

`endif

/* hw/isa_pkg.sv */
`include "rob_settings.svh"

package isa_pkg;

    // Data or PC value
    typedef logic [`XLEN-1:0] word_t;

    // Architectural register number, x0 to x31
    typedef logic [`AREG_W-1:0] areg_t;

    // What the retire unit needs to know about an instruction
    // Anything without a control-flow effect is a plain ALU result
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        // Result bit 0 carries the resolved direction
        // The upper bits carry the taken target
        KIND_BRANCH = 2'd1,
        // Target is known at decode and travels in branch_target
        KIND_JAL    = 2'd2
    } inst_kind_e;

endpackage

/* hw/rob_pkg.sv */
`include "rob_settings.svh"

package rob_pkg;

    // Slot index, also the tag carried by the CDB
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // Physical register number from rename
    typedef logic [`PREG_W-1:0] preg_t;

    // Static part of an entry
    // Written once at dispatch and read at retirement
    // The writeback result and status bits live beside it in the slot
    typedef struct packed {
        // PC of the instruction, used for pc+4 on a not-taken branch
        isa_pkg::word_t     pc;
        isa_pkg::inst_kind_e kind;
        // Direction chosen by the front end
        logic               predicted_taken;
        // Decode-time target, only meaningful for JAL
        isa_pkg::word_t     branch_target;
        isa_pkg::areg_t     dest_areg;
        preg_t              dest_preg;
    } rob_entry_t;

    // Size of one stored entry in bits
    localparam int ROB_ENTRY_W = $bits(rob_entry_t);

endpackage

/* hw/rob_alloc.sv */
`include "rob_settings.svh"

module rob_alloc (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   dispatch_valid,
    output logic                   dispatch_ready,
    output rob_pkg::rob_idx_t      dispatch_idx,

    input  logic                   commit_fire,
    input  logic                   flush,
    input  rob_pkg::rob_idx_t      flush_head,

    output logic [`ROB_DEPTH-1:0]  slot_write
);

    localparam logic [`ROB_IDX_W:0] FULL_COUNT = `ROB_DEPTH;
    localparam rob_pkg::rob_idx_t   LAST_IDX   = rob_pkg::rob_idx_t'(`ROB_DEPTH - 1);

    rob_pkg::rob_idx_t     tail;
    logic [`ROB_IDX_W:0]   count;
    logic                  full;
    logic                  dispatch_fire;

    assign full = (count == FULL_COUNT);

    // A mispredict at the head squashes the tail region this cycle
    assign dispatch_ready = !full && !flush;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign dispatch_idx   = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Everything behind the retiring branch is gone
            tail  <= flush_head;
            count <= '0;
        end else begin
            if (dispatch_fire) begin
                tail <= (tail == LAST_IDX) ? '0 : tail + 1'b1;
            end
            case ({dispatch_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One-hot write enable for the slot at the tail
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            slot_write[i] = dispatch_fire && (tail == rob_pkg::rob_idx_t'(i));
        end
    end

endmodule

/* hw/rob_slot.sv */
`include "rob_settings.svh"

module rob_slot #(
    parameter int SLOT_ID = 0
) (
    input  logic                clk,
    input  logic                rst,

    // Dispatch side
    input  logic                write,
    input  rob_pkg::rob_entry_t write_entry,

    // Common data bus
    input  logic                cdb_valid,
    input  rob_pkg::rob_idx_t   cdb_rob_idx,
    input  isa_pkg::word_t      cdb_data,

    // Retire side
    input  logic                clear,
    input  logic                flush,

    output logic                valid,
    output logic                done,
    output isa_pkg::word_t      result,
    output rob_pkg::rob_entry_t entry
);

    localparam rob_pkg::rob_idx_t MY_IDX = rob_pkg::rob_idx_t'(SLOT_ID);

    logic cdb_hit;

    // Capture only once, and only for a live entry
    assign cdb_hit = cdb_valid && (cdb_rob_idx == MY_IDX) && valid && !done;

    // Status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            done  <= 1'b0;
        end else if (clear || flush) begin
            valid <= 1'b0;
            done  <= 1'b0;
        end else if (write) begin
            // Fresh entry waits for its writeback
            valid <= 1'b1;
            done  <= 1'b0;
        end else if (cdb_hit) begin
            done  <= 1'b1;
        end
    end

    // Payload, qualified by valid and done
    always_ff @(posedge clk) begin
        if (write) begin
            entry <= write_entry;
        end
        if (cdb_hit) begin
            result <= cdb_data;
        end
    end

endmodule

/* hw/rob_retire.sv */
`include "rob_settings.svh"

module rob_retire (
    input  logic                   clk,
    input  logic                   rst,

    // State of every slot
    input  logic [`ROB_DEPTH-1:0]  slot_valid,
    input  logic [`ROB_DEPTH-1:0]  slot_done,
    input  isa_pkg::word_t         slot_result [`ROB_DEPTH],
    input  rob_pkg::rob_entry_t    slot_entry [`ROB_DEPTH],

    // Commit handshake
    output logic                   commit_valid,
    input  logic                   commit_ready,
    output isa_pkg::word_t         commit_pc,
    output isa_pkg::word_t         commit_result,
    output isa_pkg::areg_t         commit_dest_areg,
    output rob_pkg::preg_t         commit_dest_preg,

    // Control back to the allocator and the slots
    output logic                   commit_fire,
    output logic                   flush,
    output rob_pkg::rob_idx_t      flush_head,
    output logic [`ROB_DEPTH-1:0]  slot_clear,

    // Front-end redirect
    output logic                   redirect_valid,
    output isa_pkg::word_t         redirect_target
);

    localparam rob_pkg::rob_idx_t LAST_IDX = rob_pkg::rob_idx_t'(`ROB_DEPTH - 1);

    rob_pkg::rob_idx_t   head;
    rob_pkg::rob_idx_t   next_head;
    rob_pkg::rob_entry_t head_entry;
    isa_pkg::word_t      head_result;
    logic                mispredict;
    isa_pkg::word_t      target;

    assign next_head = (head == LAST_IDX) ? '0 : head + 1'b1;

    // Head selection
    assign head_entry  = slot_entry[head];
    assign head_result = slot_result[head];

    assign commit_valid     = slot_valid[head] && slot_done[head];
    assign commit_fire      = commit_valid && commit_ready;
    assign commit_pc        = head_entry.pc;
    assign commit_result    = head_result;
    assign commit_dest_areg = head_entry.dest_areg;
    assign commit_dest_preg = head_entry.dest_preg;

    // Branch resolution on the head entry
    always_comb begin
        mispredict = 1'b0;
        target     = head_entry.pc + isa_pkg::word_t'(4);
        case (head_entry.kind)
            isa_pkg::KIND_BRANCH: begin
                mispredict = (head_result[0] != head_entry.predicted_taken);
                if (head_result[0]) begin
                    target = {head_result[`XLEN-1:1], 1'b0};
                end
            end
            isa_pkg::KIND_JAL: begin
                // Always taken, so only a missed prediction needs fixing
                mispredict = !head_entry.predicted_taken;
                target     = head_entry.branch_target;
            end
            default: begin
                mispredict = 1'b0;
            end
        endcase
    end

    // The mispredicting instruction itself still retires
    assign flush      = commit_fire && mispredict;
    assign flush_head = next_head;

    // A flush clears every slot on its own line
    always_comb begin
        slot_clear = '0;
        if (commit_fire) begin
            slot_clear[head] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head           <= '0;
            redirect_valid <= 1'b0;
        end else begin
            if (commit_fire) begin
                head <= next_head;
            end
            // One-cycle pulse after the mispredicting commit
            redirect_valid <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            redirect_target <= target;
        end
    end

endmodule

/* hw/rob_top.sv */
`include "rob_settings.svh"

module rob_top (
    input  logic                clk,
    input  logic                rst,

    // Dispatch from rename
    input  logic                dispatch_valid,
    output logic                dispatch_ready,
    output rob_pkg::rob_idx_t   dispatch_idx,
    input  isa_pkg::word_t      dispatch_pc,
    input  isa_pkg::inst_kind_e dispatch_kind,
    input  logic                dispatch_predicted_taken,
    input  isa_pkg::word_t      dispatch_branch_target,
    input  isa_pkg::areg_t      dispatch_dest_areg,
    input  rob_pkg::preg_t      dispatch_dest_preg,

    // Writeback
    input  logic                cdb_valid,
    input  rob_pkg::rob_idx_t   cdb_rob_idx,
    input  isa_pkg::word_t      cdb_data,

    // Commit
    output logic                commit_valid,
    input  logic                commit_ready,
    output isa_pkg::word_t      commit_pc,
    output isa_pkg::word_t      commit_result,
    output isa_pkg::areg_t      commit_dest_areg,
    output rob_pkg::preg_t      commit_dest_preg,

    // Redirect
    output logic                redirect_valid,
    output isa_pkg::word_t      redirect_target
);

    rob_pkg::rob_entry_t    dispatch_entry;
    logic [`ROB_DEPTH-1:0]  slot_write;
    logic [`ROB_DEPTH-1:0]  slot_clear;
    logic [`ROB_DEPTH-1:0]  slot_valid;
    logic [`ROB_DEPTH-1:0]  slot_done;
    isa_pkg::word_t         slot_result [`ROB_DEPTH];
    rob_pkg::rob_entry_t    slot_entry [`ROB_DEPTH];
    logic                   commit_fire;
    logic                   flush;
    rob_pkg::rob_idx_t      flush_head;

    assign dispatch_entry = '{
        pc:              dispatch_pc,
        kind:            dispatch_kind,
        predicted_taken: dispatch_predicted_taken,
        branch_target:   dispatch_branch_target,
        dest_areg:       dispatch_dest_areg,
        dest_preg:       dispatch_dest_preg
    };

    rob_alloc u_alloc (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .commit_fire    (commit_fire),
        .flush          (flush),
        .flush_head     (flush_head),
        .slot_write     (slot_write)
    );

    for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_slot
        rob_slot #(.SLOT_ID(i)) u_slot (
            .clk         (clk),
            .rst         (rst),
            .write       (slot_write[i]),
            .write_entry (dispatch_entry),
            .cdb_valid   (cdb_valid),
            .cdb_rob_idx (cdb_rob_idx),
            .cdb_data    (cdb_data),
            .clear       (slot_clear[i]),
            .flush       (flush),
            .valid       (slot_valid[i]),
            .done        (slot_done[i]),
            .result      (slot_result[i]),
            .entry       (slot_entry[i])
        );
    end

    rob_retire u_retire (
        .clk              (clk),
        .rst              (rst),
        .slot_valid       (slot_valid),
        .slot_done        (slot_done),
        .slot_result      (slot_result),
        .slot_entry       (slot_entry),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_pc        (commit_pc),
        .commit_result    (commit_result),
        .commit_dest_areg (commit_dest_areg),
        .commit_dest_preg (commit_dest_preg),
        .commit_fire      (commit_fire),
        .flush            (flush),
        .flush_head       (flush_head),
        .slot_clear       (slot_clear),
        .redirect_valid   (redirect_valid),
        .redirect_target  (redirect_target)
    );

endmodule

/* verification/rob_sva.sv */
module rob_sva (
    input logic              clk,
    input logic              rst,
    input logic              dispatch_valid,
    input logic              dispatch_ready,
    input rob_pkg::rob_idx_t dispatch_idx,
    input logic              commit_valid,
    input logic              commit_ready,
    input isa_pkg::word_t    commit_pc,
    input isa_pkg::word_t    commit_result,
    input rob_pkg::preg_t    commit_dest_preg,
    input logic              redirect_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Quiet outputs straight out of reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !commit_valid && !redirect_valid)
        else $error("commit or redirect active right after reset");

    a_ready_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> dispatch_ready)
        else $error("dispatch not ready after reset");

    // Tail moves by one slot per transfer and wraps
    a_idx_step: assert property (@(posedge clk) disable iff (rst)
        (dispatch_valid && dispatch_ready) |=>
            dispatch_idx == rob_pkg::rob_idx_t'($past(dispatch_idx) + 1'b1))
        else $error("dispatch index did not advance by one");

    // Head holds under back-pressure
    a_commit_hold: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready) |=>
            commit_valid && $stable(commit_pc) && $stable(commit_result)
            && $stable(commit_dest_preg))
        else $error("commit outputs changed while stalled");

    a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else $error("redirect longer than one cycle");

endmodule

bind rob_top rob_sva u_sva (.*);

/* verification/rob_tb.sv */
`include "rob_settings.svh"

module rob_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;

    typedef struct {
        isa_pkg::word_t      pc;
        isa_pkg::inst_kind_e kind;
        logic                pred;
        isa_pkg::word_t      tgt;
        isa_pkg::areg_t      areg;
        rob_pkg::preg_t      preg;
        isa_pkg::word_t      data;
        rob_pkg::rob_idx_t   idx;
        // 0 waiting, 1 on the CDB, 2 captured
        int                  wb;
    } inst_t;

    logic clk = 1'b0;
    logic rst;
    logic dispatch_valid, dispatch_ready, dispatch_predicted_taken;
    rob_pkg::rob_idx_t dispatch_idx, cdb_rob_idx;
    isa_pkg::word_t dispatch_pc, dispatch_branch_target, cdb_data;
    isa_pkg::inst_kind_e dispatch_kind;
    isa_pkg::areg_t dispatch_dest_areg, commit_dest_areg;
    rob_pkg::preg_t dispatch_dest_preg, commit_dest_preg;
    logic cdb_valid, commit_valid, commit_ready, redirect_valid;
    isa_pkg::word_t commit_pc, commit_result, redirect_target;

    integer seed = 33;
    int cycles = 0;
    int data_errors = 0;
    int other_errors = 0;
    inst_t q[$];
    inst_t nxt;
    logic nxt_have = 1'b0;
    int budget = 0;
    int gen_mode = 0;
    int ready_mode = 1;
    isa_pkg::word_t pc_count = 32'h0000_1000;
    rob_pkg::rob_idx_t exp_tail = '0;
    logic redir_exp = 1'b0;
    isa_pkg::word_t redir_tgt;

    rob_top UUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errors++;
            $display("Errors: %0d data, %0d other", data_errors, other_errors);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        data_errors++;
    endtask

    // Mode 0 makes ALU entries, mode 1 mixes branches and JAL
    function automatic inst_t make_inst(input int mode);
        inst_t t;
        logic taken;
        t.pc   = pc_count;
        t.areg = $random(seed);
        t.preg = $random(seed);
        t.pred = $random(seed);
        t.tgt  = {$random(seed)} & 32'hffff_fffc;
        t.data = $random(seed);
        t.wb   = 0;
        t.idx  = '0;
        t.kind = isa_pkg::KIND_ALU;
        if (mode == 1) begin
            case ({$random(seed)} % 3)
                0: t.kind = isa_pkg::KIND_ALU;
                1: t.kind = isa_pkg::KIND_BRANCH;
                default: t.kind = isa_pkg::KIND_JAL;
            endcase
        end
        if (t.kind == isa_pkg::KIND_BRANCH) begin
            taken = $random(seed);
            t.data = {t.data[31:1], taken};
        end else if (t.kind == isa_pkg::KIND_JAL) begin
            t.data = t.pc + 32'd4;
        end
        pc_count = pc_count + 32'd4;
        return t;
    endfunction

    // Stimulus on the rising edge
    always @(posedge clk) begin
        int pending;
        int pick;
        if (!rst) begin
            foreach (q[i]) begin
                if (q[i].wb == 1) q[i].wb = 2;
            end
            cdb_valid <= 1'b0;
            pending = 0;
            foreach (q[i]) begin
                if (q[i].wb == 0) pending++;
            end
            if (pending > 0 && $random(seed) % 2 == 0) begin
                pick = {$random(seed)} % pending;
                foreach (q[i]) begin
                    if (q[i].wb == 0) begin
                        if (pick == 0) begin
                            cdb_valid   <= 1'b1;
                            cdb_rob_idx <= q[i].idx;
                            cdb_data    <= q[i].data;
                            q[i].wb = 1;
                        end
                        pick--;
                    end
                end
            end
            case (ready_mode)
                0: commit_ready <= 1'b0;
                1: commit_ready <= $random(seed);
                default: commit_ready <= 1'b1;
            endcase
            if (!nxt_have && budget > 0 && $random(seed) % 4 != 0) begin
                nxt = make_inst(gen_mode);
                nxt_have = 1'b1;
                budget--;
            end
            dispatch_valid           <= nxt_have;
            dispatch_pc              <= nxt.pc;
            dispatch_kind            <= nxt.kind;
            dispatch_predicted_taken <= nxt.pred;
            dispatch_branch_target   <= nxt.tgt;
            dispatch_dest_areg       <= nxt.areg;
            dispatch_dest_preg       <= nxt.preg;
        end
    end

    // Reference model sampled mid-cycle
    always @(negedge clk) begin
        inst_t h;
        logic mis;
        logic flush_now;
        logic exp_cv;
        logic exp_ready;
        isa_pkg::word_t tgt;
        int sz0;
        if (!rst) begin
            flush_now = 1'b0;
            sz0 = q.size();
            assert (redirect_valid === redir_exp)
                else report_mismatch("redirect_valid", redirect_valid, redir_exp);
            if (redir_exp && redirect_valid === 1'b1) begin
                assert (redirect_target === redir_tgt)
                    else report_mismatch("redirect_target", redirect_target, redir_tgt);
            end
            redir_exp = 1'b0;
            exp_cv = (sz0 > 0) && (q[0].wb == 2);
            assert (commit_valid === exp_cv)
                else report_mismatch("commit_valid", commit_valid, exp_cv);
            if (commit_valid && commit_ready && sz0 > 0) begin
                h = q.pop_front();
                assert (commit_pc === h.pc)
                    else report_mismatch("commit_pc", commit_pc, h.pc);
                assert (commit_dest_areg === h.areg)
                    else report_mismatch("commit_dest_areg", commit_dest_areg, h.areg);
                assert (commit_dest_preg === h.preg)
                    else report_mismatch("commit_dest_preg", commit_dest_preg, h.preg);
                assert (commit_result === h.data)
                    else report_mismatch("commit_result", commit_result, h.data);
                mis = 1'b0;
                tgt = h.pc + 32'd4;
                if (h.kind == isa_pkg::KIND_BRANCH) begin
                    mis = (h.data[0] != h.pred);
                    if (h.data[0]) tgt = {h.data[31:1], 1'b0};
                end else if (h.kind == isa_pkg::KIND_JAL) begin
                    mis = !h.pred;
                    tgt = h.tgt;
                end
                if (mis) begin
                    // Younger entries are squashed
                    flush_now = 1'b1;
                    redir_exp = 1'b1;
                    redir_tgt = tgt;
                    q.delete();
                    exp_tail = h.idx + 1'b1;
                end
            end
            exp_ready = (sz0 < `ROB_DEPTH) && !flush_now;
            assert (dispatch_ready === exp_ready)
                else report_mismatch("dispatch_ready", dispatch_ready, exp_ready);
            if (dispatch_valid && dispatch_ready) begin
                assert (dispatch_idx === exp_tail)
                    else report_mismatch("dispatch_idx", dispatch_idx, exp_tail);
                nxt.idx = exp_tail;
                q.push_back(nxt);
                exp_tail = exp_tail + 1'b1;
                nxt_have = 1'b0;
            end
        end
    end

    task automatic drain;
        while (!(budget == 0 && !nxt_have && q.size() == 0)) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_kind = isa_pkg::KIND_ALU;
        dispatch_predicted_taken = 1'b0;
        dispatch_branch_target = '0;
        dispatch_dest_areg = '0;
        dispatch_dest_preg = '0;
        cdb_valid = 1'b0;
        cdb_rob_idx = '0;
        cdb_data = '0;
        commit_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // Random ALU traffic
        gen_mode = 0;
        ready_mode = 1;
        budget = 40;
        drain();
        // Back-pressure until the buffer is full
        ready_mode = 0;
        budget = 24;
        while (q.size() < `ROB_DEPTH) @(negedge clk);
        repeat (6) @(negedge clk);
        ready_mode = 2;
        drain();
        // Branches, JAL and ALU mixed
        gen_mode = 1;
        ready_mode = 1;
        budget = 80;
        drain();
        $display("Errors: %0d data, %0d other", data_errors, other_errors);
        if (data_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_slot.sv
hw/rob_retire.sv
hw/rob_top.sv
verification/rob_sva.sv
verification/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
